// File: Makefile
# Verilator build and run for the serial bus slave.
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = bus_slave_tb
FILELIST  = sources.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
PASS_MSG  = test passed
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Checker errors let the run continue so the testbench can report them.
run: $(SIM)
	./$(SIM) +verilator+error+limit+1000 > $(LOG) 2>&1; cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/bus_slave_checker.sv
// #########################################################################
// Protocol assertions for the serial bus slave, bound into bus_slave and
// sampled on the rising clock.
// #########################################################################

`timescale 1ns/1ps
`default_nettype none

module bus_slave_checker
(
	input wire clk,
	input wire reset,
	input wire rx_ready,
	input wire tx_pending,
	input wire master_ready,
	input wire tx_done,
	input wire read_strobe
);

	int failures = 0;  // Failed assertions so far.

	// tx_done comes with bit 7, eight clocks after the handshake edge.
	done_on_bit_seven: assert property (@(posedge clk) disable iff (reset)
		tx_done == $past(tx_pending && master_ready, 8))
	else
	begin
		failures++;
		$error("tx_done did not line up with bit 7 of the transfer");
	end

	// The byte stays offered until the master takes it.
	pending_until_ready: assert property (@(posedge clk) disable iff (reset)
		$past(tx_pending && !master_ready) |-> tx_pending)
	else
	begin
		failures++;
		$error("tx_pending dropped before master_ready was seen");
	end

	// No new frame while a byte is offered or its last bit is on the line.
	blocked_while_busy: assert property (@(posedge clk) disable iff (reset)
		(tx_pending || tx_done) |-> !rx_ready)
	else
	begin
		failures++;
		$error("rx_ready was high while a read was still in flight");
	end

	// A decoded read is offered to the master two clocks later.
	read_offered_in_time: assert property (@(posedge clk) disable iff (reset)
		$past(read_strobe, 2) |-> tx_pending)
	else
	begin
		failures++;
		$error("a decoded read did not raise tx_pending two clocks later");
	end

endmodule

bind bus_slave bus_slave_checker u_checker (.*);

`default_nettype wire

// File: dv/bus_slave_tb.sv
// #########################################################################
// Testbench for the serial bus slave. Sends seeded random write and read
// frames, mirrors the writes in a reference memory and checks each read.
// #########################################################################

`timescale 1ns/1ps
`default_nettype none

module bus_slave_tb;

	logic clk;
	logic reset;
	logic rx_valid;
	logic rx_data;
	logic master_ready;
	wire  rx_ready;
	wire  tx_pending;
	wire  tx_data;
	wire  tx_done;

	// Latest byte written to each address.
	logic [slave_bus_pkg::data_width-1:0] ref_mem [slave_bus_pkg::mem_depth];
	logic [slave_bus_pkg::addr_width-1:0] addr_pool [6];  // Small, so writes overwrite.
	logic [slave_bus_pkg::addr_width-1:0] addr;
	logic [2:0]  k;
	int unsigned seed_result;
	int          n;

	bus_slave uut (.*);

	always #5 clk = ~clk;  // 10 ns period.

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("test failed");
		$fatal(1);
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		assert (got === exp)
		else
			stop_with_error($sformatf("CHECK FAILED: %s = 0x%0h, expected 0x%0h",
				name, got, exp));
	endtask

	// Bound checker status.
	always @(negedge clk)
	begin
		if (uut.u_checker.failures != 0)
			stop_with_error("a protocol assertion in the checker failed");
	end

	// #########################################################################
	// Master side of the request line.
	// #########################################################################
	// Mode bit first, then the rest of the frame from its top bit down.
	task automatic send_frame(input logic mode, input logic [11:0] fr_addr,
		input logic [7:0] fr_data);
		logic [20:0] bits;
		int          len;
		int          count;

		bits  = {mode, fr_addr, fr_data};
		len   = (mode == slave_bus_pkg::mode_write) ?
			slave_bus_pkg::write_frame_bits : slave_bus_pkg::read_frame_bits;
		count = 0;
		while (!rx_ready)
		begin
			@(negedge clk);
			count++;
			if (count > 100)
				stop_with_error("timeout waiting for rx_ready before a frame");
		end
		repeat (len)
		begin
			rx_valid = 1'b1;
			rx_data  = bits[20];
			bits     = bits << 1;
			@(negedge clk);
		end
		rx_valid = 1'b0;
		rx_data  = 1'b0;
	endtask

	task automatic write_and_record(input logic [11:0] wr_addr, input logic [7:0] wr_data);
		send_frame(slave_bus_pkg::mode_write, wr_addr, wr_data);
		ref_mem[wr_addr] = wr_data;
	endtask

	// Read one address. The master holds off for stall cycles first.
	task automatic read_and_check(input logic [11:0] rd_addr, input int stall);
		logic [7:0] value;
		int         count;
		int         i;

		send_frame(slave_bus_pkg::mode_read, rd_addr, 8'h00);
		count = 0;
		while (!tx_pending)
		begin
			@(negedge clk);
			count++;
			if (count > 100)
				stop_with_error("timeout waiting for tx_pending after a read frame");
		end
		repeat (stall)
		begin
			check_bit("rx_ready", rx_ready, 1'b0);  // No new frame may start.
			@(negedge clk);
			check_bit("tx_pending", tx_pending, 1'b1);
		end
		master_ready = 1'b1;
		for (i = 0; i < 8; i++)
		begin
			@(negedge clk);
			master_ready = 1'b0;
			value = {tx_data, value[7:1]};  // LSB arrives first.
			check_bit("tx_done", tx_done, i == 7);
			check_bit("tx_pending", tx_pending, 1'b0);
			check_bit("rx_ready", rx_ready, 1'b0);
		end
		assert (value === ref_mem[rd_addr])
		else
			stop_with_error($sformatf("CHECK FAILED: tx_data byte = 0x%0h, expected 0x%0h",
				value, ref_mem[rd_addr]));
	endtask

	// #########################################################################
	// Test sequence.
	// #########################################################################
	initial
	begin
		clk          = 1'b0;
		reset        = 1'b1;
		rx_valid     = 1'b0;
		rx_data      = 1'b0;
		master_ready = 1'b0;
		seed_result  = $urandom(32'h776e3464);
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// Idle outputs.
		check_bit("rx_ready", rx_ready, 1'b1);
		check_bit("tx_pending", tx_pending, 1'b0);
		check_bit("tx_done", tx_done, 1'b0);
		check_bit("tx_data", tx_data, 1'b0);

		// One write and its read back, master ready at once.
		addr = 12'($urandom);
		write_and_record(addr, 8'($urandom));
		read_and_check(addr, 0);

		// Pool holds both address extremes plus random ones.
		addr_pool[0] = 12'h000;
		addr_pool[1] = 12'hfff;
		for (k = 3'd0; k < 3'd6; k++)
		begin
			if (k > 3'd1)
				addr_pool[k] = 12'($urandom);
			write_and_record(addr_pool[k], 8'($urandom));
		end

		// Mixed traffic with random master stalls on reads.
		for (n = 0; n < 40; n++)
		begin
			k = 3'($urandom_range(0, 5));
			if ($urandom_range(0, 2) == 0)
				read_and_check(addr_pool[k], int'($urandom_range(0, 15)));
			else
				write_and_record(addr_pool[k], 8'($urandom));
		end
		for (k = 3'd0; k < 3'd6; k++)
			read_and_check(addr_pool[k], int'($urandom_range(0, 4)));

		if (uut.u_checker.failures != 0)
		begin
			stop_with_error("a protocol assertion in the checker failed");
		end
		else
		begin
			$display("test passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: hw/bus_slave.sv
// #########################################################################
// Serial bus slave port. Ties the receive, decode, memory and transmit
// stages to the serial pins of the master.
// #########################################################################

`timescale 1ns/1ps
`default_nettype none

module bus_slave
(
	input  wire  clk,
	input  wire  reset,
	input  wire  rx_valid,
	input  wire  rx_data,
	input  wire  master_ready,
	output logic rx_ready,
	output logic tx_pending,
	output logic tx_data,
	output logic tx_done
);

	slave_bus_pkg::frame_t                frame;
	logic                                 frame_strobe;
	logic                                 write_strobe;
	logic                                 read_strobe;
	logic [slave_bus_pkg::addr_width-1:0] addr;
	logic [slave_bus_pkg::data_width-1:0] wdata;
	logic                                 read_strobe_out;
	logic [slave_bus_pkg::data_width-1:0] read_data;
	logic                                 busy;  // Read in flight.

	slave_in_port u_in_port (
		.clk          (clk),
		.reset        (reset),
		.rx_valid     (rx_valid),
		.rx_data      (rx_data),
		.busy         (busy),
		.rx_ready     (rx_ready),
		.frame_strobe (frame_strobe),
		.frame        (frame)
	);

	request_decode u_decode (
		.clk          (clk),
		.reset        (reset),
		.frame_strobe (frame_strobe),
		.frame        (frame),
		.write_strobe (write_strobe),
		.read_strobe  (read_strobe),
		.addr         (addr),
		.wdata        (wdata)
	);

	memory_execute u_execute (
		.clk             (clk),
		.reset           (reset),
		.write_strobe    (write_strobe),
		.read_strobe     (read_strobe),
		.addr            (addr),
		.wdata           (wdata),
		.read_strobe_out (read_strobe_out),
		.read_data       (read_data)
	);

	// Pending read byte shows up as tx_pending.
	slave_out_port u_out_port (
		.clk          (clk),
		.reset        (reset),
		.read_strobe  (read_strobe),
		.load         (read_strobe_out),
		.load_data    (read_data),
		.master_ready (master_ready),
		.busy         (busy),
		.slave_valid  (tx_pending),
		.tx_data      (tx_data),
		.tx_done      (tx_done)
	);

endmodule

`default_nettype wire

// File: hw/memory_execute.sv
// #########################################################################
// Execute stage. The slave's byte memory. Writes land on the strobe edge,
// reads return their byte one clock later with a valid pulse.
// #########################################################################

`timescale 1ns/1ps
`default_nettype none

module memory_execute
(
	input  wire                                   clk,
	input  wire                                   reset,
	input  wire                                   write_strobe,
	input  wire                                   read_strobe,
	input  wire [slave_bus_pkg::addr_width-1:0]   addr,
	input  wire [slave_bus_pkg::data_width-1:0]   wdata,
	output logic                                  read_strobe_out,
	output logic [slave_bus_pkg::data_width-1:0]  read_data
);

	// #########################################################################
	// Storage.
	// #########################################################################
	// One byte per address, contents undefined after power up.
	logic [slave_bus_pkg::data_width-1:0] mem [slave_bus_pkg::mem_depth];

	always_ff @(posedge clk)
	begin
		if (write_strobe)
		begin
			mem[addr] <= wdata;
		end
	end

	// Registered read port.
	always_ff @(posedge clk)
	begin
		if (read_strobe)
		begin
			read_data <= mem[addr];
		end
	end

	// #########################################################################
	// Read valid.
	// #########################################################################
	// Only one request arrives per cycle, so a pulse here always
	// matches the byte just captured above.
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			read_strobe_out <= 1'b0;
		end
		else
		begin
			read_strobe_out <= read_strobe;  // Same cycle as read_data.
		end
	end

endmodule

`default_nettype wire

// File: hw/request_decode.sv
// #########################################################################
// Decode stage. Reads a finished frame through the view its mode bit
// selects and issues one registered write or read request.
// #########################################################################

`timescale 1ns/1ps
`default_nettype none

module request_decode
(
	input  wire                                   clk,
	input  wire                                   reset,
	input  wire                                   frame_strobe,
	input  wire slave_bus_pkg::frame_t            frame,
	output logic                                  write_strobe,
	output logic                                  read_strobe,
	output logic [slave_bus_pkg::addr_width-1:0]  addr,
	output logic [slave_bus_pkg::data_width-1:0]  wdata
);

	logic frame_is_write;

	// Mode sits in the same place in both views.
	assign frame_is_write = (frame.wr.mode == slave_bus_pkg::mode_write);

	// Request strobes, one cycle after the frame strobe.
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			write_strobe <= 1'b0;
			read_strobe  <= 1'b0;
		end
		else
		begin
			write_strobe <= frame_strobe && frame_is_write;
			read_strobe  <= frame_strobe && !frame_is_write;
		end
	end

	// Address and data ride along with the strobe.
	always_ff @(posedge clk)
	begin
		if (frame_strobe)
		begin
			if (frame_is_write)
			begin
				addr  <= frame.wr.addr;  // Upper field in a long frame.
				wdata <= frame.wr.data;
			end
			else
			begin
				addr <= frame.rd.addr;   // Low bits in a short frame.
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/slave_bus_pkg.sv
// #########################################################################
// Shared widths, mode encoding and the received frame layout for the
// serial bus slave. Modules refer to these by scoped name.
// #########################################################################

`default_nettype none

package slave_bus_pkg;

	// #########################################################################
	// Frame geometry.
	// #########################################################################
	localparam int addr_width       = 12;
	localparam int data_width       = 8;
	localparam int write_frame_bits = 21;  // Mode, address, data.
	localparam int read_frame_bits  = 13;  // Mode, address.

	// Byte memory behind the port.
	localparam int mem_depth = 4096;

	// First bit of every frame.
	localparam logic mode_write = 1'b1;
	localparam logic mode_read  = 1'b0;

	// #########################################################################
	// Received frame word.
	// #########################################################################
	// The mode bit always lands in the top bit. A write frame fills the
	// remaining 20 bits, while a read frame stops after 12 and leaves its
	// address in the low bits with zero padding above it.
	typedef union packed
	{
		struct packed
		{
			logic mode;
			logic [addr_width-1:0] addr;
			logic [data_width-1:0] data;
		} wr;
		struct packed
		{
			logic mode;
			logic [write_frame_bits-read_frame_bits-1:0] pad;  // Zero for reads.
			logic [addr_width-1:0] addr;
		} rd;
	} frame_t;

endpackage

`default_nettype wire

// File: hw/slave_in_port.sv
// #########################################################################
// Request deserializer. Collects master request bits, mode bit first, and
// presents the finished frame word with a one-cycle strobe.
// #########################################################################

`timescale 1ns/1ps
`default_nettype none

module slave_in_port
(
	input  wire                  clk,
	input  wire                  reset,
	input  wire                  rx_valid,
	input  wire                  rx_data,
	input  wire                  busy,
	output logic                 rx_ready,
	output logic                 frame_strobe,
	output slave_bus_pkg::frame_t frame
);

	logic       receiving;   // A frame is being shifted in.
	logic       is_write;    // Length selected by the mode bit.
	logic [4:0] bit_count;   // Bits taken so far in this frame.
	logic       start_bit;
	logic       next_bit;
	logic       last_bit;

	// Not ready while a frame is in progress, while it is handed off, or
	// while a read is still being served.
	assign rx_ready = !receiving && !frame_strobe && !busy;

	assign start_bit = rx_valid && rx_ready;
	assign next_bit  = rx_valid && receiving;

	// Final bit of a write or a read frame.
	assign last_bit = is_write ?
		(bit_count == 5'(slave_bus_pkg::write_frame_bits - 1)) :
		(bit_count == 5'(slave_bus_pkg::read_frame_bits - 1));

	// #########################################################################
	// Frame control.
	// #########################################################################
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			receiving    <= 1'b0;
			is_write     <= 1'b0;
			bit_count    <= '0;
			frame_strobe <= 1'b0;
		end
		else
		begin
			frame_strobe <= 1'b0;
			if (start_bit)
			begin
				receiving <= 1'b1;
				is_write  <= (rx_data == slave_bus_pkg::mode_write);
				bit_count <= 5'd1;
			end
			else if (next_bit)
			begin
				bit_count <= bit_count + 5'd1;
				if (last_bit)
				begin
					receiving    <= 1'b0;
					frame_strobe <= 1'b1;  // Seen on the clock after the last bit.
				end
			end
		end
	end

	// #########################################################################
	// Shift register.
	// #########################################################################
	always_ff @(posedge clk)
	begin
		if (start_bit)
		begin
			// Mode goes straight to the top, the rest starts cleared.
			frame <= {rx_data, {(slave_bus_pkg::write_frame_bits - 1){1'b0}}};
		end
		else if (next_bit)
		begin
			// Payload bits enter at the bottom, below the mode bit.
			frame <= {frame.wr.mode,
				frame[slave_bus_pkg::write_frame_bits-3:0], rx_data};
		end
	end

endmodule

`default_nettype wire

// File: hw/slave_out_port.sv
// #########################################################################
// Result stage. Holds a read byte, offers it with slave_valid and shifts
// it out LSB first over eight clocks once the master is ready.
// #########################################################################

`timescale 1ns/1ps
`default_nettype none

module slave_out_port
(
	input  wire                                 clk,
	input  wire                                 reset,
	input  wire                                 read_strobe,
	input  wire                                 load,
	input  wire [slave_bus_pkg::data_width-1:0] load_data,
	input  wire                                 master_ready,
	output logic                                busy,
	output logic                                slave_valid,
	output logic                                tx_data,
	output logic                                tx_done
);

	logic [slave_bus_pkg::data_width-1:0] data_reg;  // Byte being sent.
	logic       shifting;   // Bits 1 to 7 still to go.
	logic [2:0] bit_idx;    // Next bit to drive.
	logic       busy_reg;
	logic       handshake;

	assign handshake = slave_valid && master_ready;

	// Busy starts with the decoded read and lasts through the last bit.
	assign busy = read_strobe || busy_reg;

	// Read byte capture.
	always_ff @(posedge clk)
	begin
		if (load)
		begin
			data_reg <= load_data;
		end
	end

	// #########################################################################
	// Handshake and serializer.
	// #########################################################################
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			slave_valid <= 1'b0;
			shifting    <= 1'b0;
			bit_idx     <= '0;
			tx_data     <= 1'b0;
			tx_done     <= 1'b0;
		end
		else
		begin
			tx_done <= 1'b0;
			if (load)
			begin
				slave_valid <= 1'b1;
			end
			else if (handshake)
			begin
				slave_valid <= 1'b0;  // Drops with the first bit.
			end

			if (handshake)
			begin
				tx_data  <= data_reg[0];
				bit_idx  <= 3'd1;
				shifting <= 1'b1;
			end
			else if (shifting)
			begin
				tx_data <= data_reg[bit_idx];
				bit_idx <= bit_idx + 3'd1;
				if (bit_idx == 3'd7)
				begin
					shifting <= 1'b0;
					tx_done  <= 1'b1;  // Marks bit 7.
				end
			end
			else
			begin
				tx_data <= 1'b0;  // Line idles low.
			end
		end
	end

	// Held until the cycle carrying bit 7 has passed.
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			busy_reg <= 1'b0;
		else if (read_strobe)
			busy_reg <= 1'b1;
		else if (tx_done)
			busy_reg <= 1'b0;
	end

endmodule

`default_nettype wire

// File: sources.f
hw/slave_bus_pkg.sv
hw/slave_in_port.sv
hw/request_decode.sv
hw/memory_execute.sv
hw/slave_out_port.sv
hw/bus_slave.sv
dv/bus_slave_checker.sv
dv/bus_slave_tb.sv
